// File: apb_periph_sys.f
periph_pkg.sv
keypad_pkg.sv
apb_slave_mux.sv
apb_led.sv
keypad_scan.sv
key_debounce.sv
apb_keypad.sv
apb_periph_sys.sv
tb_apb_periph_sys.sv

// File: Bender.yml
package:
  name: apb_periph_sys

sources:
  - periph_pkg.sv
  - keypad_pkg.sv
  - apb_slave_mux.sv
  - apb_led.sv
  - keypad_scan.sv
  - key_debounce.sv
  - apb_keypad.sv
  - apb_periph_sys.sv
  - target: test
    files:
      - tb_apb_periph_sys.sv

// File: tb_apb_periph_sys.sv
//--------------------
// Testbench for the APB peripheral subsystem
// Clock, reset, keypad model, APB tasks, stimulus,
// assertions and watchdog
//--------------------

`timescale 1ns/1ps

module tb_apb_periph_sys;

    import periph_pkg::*;
    import keypad_pkg::*;

    localparam int SCAN_DIV        = 4;
    localparam int DEBOUNCE_CYCLES = 6;
    localparam int KEY_LAT    = KP_ROWS * SCAN_DIV + DEBOUNCE_CYCLES + 3;
    localparam int POLL_LIMIT = KEY_LAT + 4;    // Model lag and read granularity
    localparam int N_LED      = 8;
    localparam int N_KEYS     = 4;
    localparam int NUM_TESTS  = N_LED + 14 + N_KEYS + 3;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * KEY_LAT * 4;
    localparam int READY_LIMIT = 4;

    logic                  clk;
    logic                  RSTn;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    logic [KP_COLS-1:0]    col;
    logic [KP_ROWS-1:0]    row;
    logic [LED_WIDTH-1:0]  led;
    logic                  irq;
    key_vec_t              pressed;         // Keys held on the modelled pad
    integer                seed;
    logic                  access;
    logic [SLOT_W-1:0]     cur_slot;
    logic [OFFS_W-1:0]     cur_off;

    apb_periph_sys #(
        .SCAN_DIV        (SCAN_DIV),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) dut_i (
        .clk     (clk),
        .RSTn    (RSTn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .col     (col),
        .row     (row),
        .led     (led),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pressed key shorts its row to its column
    always @(posedge clk) begin : keypad_model
        logic [KP_COLS-1:0] c_val;
        c_val = '1;
        for (int r = 0; r < KP_ROWS; r++) begin
            for (int c = 0; c < KP_COLS; c++) begin
                if (!row[r] && pressed[r*KP_COLS+c]) c_val[c] = 1'b0;
            end
        end
        col <= c_val;
    end

    //--------------------
    // Failure reporting
    //--------------------
    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    //--------------------
    // APB tasks
    //--------------------
    function automatic logic [APB_ADDR_W-1:0] make_addr(input logic [SLOT_W-1:0] slot,
                                                        input logic [OFFS_W-1:0] offset);
        apb_addr_u a;
        a.raw      = '0;
        a.f.slot   = slot;
        a.f.offset = offset;
        return a.raw;
    endfunction

    task automatic start_access(input logic [APB_ADDR_W-1:0] addr_raw, input logic is_write,
                                input logic [APB_DATA_W-1:0] data);
        @(posedge clk);
        apb_req.sel      <= 1'b1;       // Setup phase
        apb_req.enable   <= 1'b0;
        apb_req.write    <= is_write;
        apb_req.addr.raw <= addr_raw;
        apb_req.wdata    <= data;
        @(posedge clk);
        apb_req.enable   <= 1'b1;       // Access phase
    endtask

    task automatic finish_access(output logic [APB_DATA_W-1:0] data, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        while (!apb_rsp.ready && waited < READY_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!apb_rsp.ready) begin
            $display("No ready from the DUT within %0d access cycles", READY_LIMIT);
            stop_on_failure();
        end else begin
            data           = apb_rsp.rdata;
            err            = apb_rsp.slverr;
            apb_req.sel    <= 1'b0;
            apb_req.enable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr_raw,
                             input logic [APB_DATA_W-1:0] data);
        logic [APB_DATA_W-1:0] unused_rdata;
        logic                  unused_err;
        start_access(addr_raw, 1'b1, data);
        finish_access(unused_rdata, unused_err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr_raw,
                            output logic [APB_DATA_W-1:0] data, output logic err);
        start_access(addr_raw, 1'b0, '0);
        finish_access(data, err);
    endtask

    // Poll the key state register until key k reaches level
    task automatic wait_key_state(input int k, input logic level);
        logic [APB_DATA_W-1:0] data;
        logic                  err;
        int                    waited;
        waited = 0;
        apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATE), data, err);
        while (data[k] !== level && waited < POLL_LIMIT) begin
            apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATE), data, err);
            waited += 3;
        end
        assert (data[k] === level) else begin
            $display("Key %0d did not reach state %0b within %0d cycles", k, level, POLL_LIMIT);
            stop_on_failure();
        end
    endtask

    //--------------------
    // Bus assertions
    //--------------------
    assign access   = apb_req.sel && apb_req.enable;
    assign cur_slot = apb_req.addr.f.slot;
    assign cur_off  = apb_req.addr.f.offset;

    a_ready: assert property (@(posedge clk) disable iff (!RSTn) access |-> apb_rsp.ready)
        else begin
            $display("Mismatch at %0t ns: ready is %0b, expected 1", $time,
                     $sampled(apb_rsp.ready));
            stop_on_failure();
        end

    a_unmapped_err: assert property (@(posedge clk) disable iff (!RSTn)
        (access && cur_slot > SLOT_KEYPAD) |-> apb_rsp.slverr)
        else begin
            $display("Mismatch at %0t ns: slverr is 0, expected 1", $time);
            stop_on_failure();
        end

    a_unmapped_data: assert property (@(posedge clk) disable iff (!RSTn)
        (access && cur_slot > SLOT_KEYPAD) |-> (apb_rsp.rdata == '0))
        else begin
            $display("Mismatch at %0t ns: rdata is 0x%0h, expected 0x0", $time,
                     $sampled(apb_rsp.rdata));
            stop_on_failure();
        end

    a_mapped_ok: assert property (@(posedge clk) disable iff (!RSTn)
        (access && cur_slot <= SLOT_KEYPAD) |-> !apb_rsp.slverr)
        else begin
            $display("Mismatch at %0t ns: slverr is 1, expected 0", $time);
            stop_on_failure();
        end

    // LED follows a data write one cycle after the access phase
    a_led_load: assert property (@(posedge clk) disable iff (!RSTn)
        (access && apb_req.write && cur_slot == SLOT_LED && cur_off == REG_LED_DATA)
        |=> (led == $past(apb_req.wdata[LED_WIDTH-1:0])))
        else begin
            $display("Mismatch at %0t ns: led is 0x%0h, expected 0x%0h", $time,
                     $sampled(led), $past(apb_req.wdata[LED_WIDTH-1:0]));
            stop_on_failure();
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        stop_on_failure();
    end

    //--------------------
    // Stimulus
    //--------------------
    initial begin
        logic [APB_DATA_W-1:0] data;
        logic [APB_DATA_W-1:0] val;
        logic                  err;
        int                    k;

        seed    = 83653;
        RSTn    = 1'b0;
        apb_req = '0;
        col     = '1;
        pressed = '0;
        repeat (16) @(posedge clk);
        RSTn <= 1'b1;
        @(posedge clk);

        // Reset values
        check_value("led", 32'(led), 32'h0);
        check_value("irq", 32'(irq), 32'h0);
        check_value("row", 32'(row), 32'(4'b1110));    // Row 0 driven low
        apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATE), data, err);
        check_value("key_state", data, 32'h0);

        // LED writes with readback
        for (int i = 0; i < N_LED; i++) begin
            val = $random(seed);
            apb_write(make_addr(SLOT_LED, REG_LED_DATA), val);
            @(posedge clk);
            check_value("led", 32'(led), 32'(val[LED_WIDTH-1:0]));
            apb_read(make_addr(SLOT_LED, REG_LED_DATA), data, err);
            check_value("led_data", data, 32'(val[LED_WIDTH-1:0]));
        end
        apb_read(make_addr(SLOT_LED, 4'd4), data, err);
        check_value("led_unused", data, 32'h0);

        // Unmapped slots answer with an error
        for (int s = 2; s < 16; s++) begin
            val = $random(seed);
            if (val[0]) begin
                apb_write(make_addr(4'(s), val[7:4]), val);
            end else begin
                apb_read(make_addr(4'(s), val[7:4]), data, err);
                check_value("slverr", 32'(err), 32'h1);
            end
        end

        // Random key press and release
        for (int i = 0; i < N_KEYS; i++) begin
            k = {$random(seed)} % KP_KEYS;
            @(posedge clk);
            pressed <= key_vec_t'(1) << k;
            wait_key_state(k, 1'b1);
            apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATE), data, err);
            check_value("key_state", data, 32'(1) << k);
            @(posedge clk);
            pressed <= '0;
            wait_key_state(k, 1'b0);
        end

        // Status, enable and irq
        k = {$random(seed)} % KP_KEYS;
        apb_write(make_addr(SLOT_KEYPAD, REG_KEY_STATUS), 32'hFFFF);
        apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATUS), data, err);
        check_value("key_status", data, 32'h0);
        apb_write(make_addr(SLOT_KEYPAD, REG_KEY_ENABLE), ~(32'(1) << k) & 32'hFFFF);
        @(posedge clk);
        pressed <= key_vec_t'(1) << k;
        wait_key_state(k, 1'b1);
        repeat (3) @(posedge clk);
        check_value("irq", 32'(irq), 32'h0);        // Other keys enabled only
        apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATUS), data, err);
        check_value("key_status", data, 32'(1) << k);
        apb_write(make_addr(SLOT_KEYPAD, REG_KEY_ENABLE), 32'(1) << k);
        repeat (2) @(posedge clk);
        check_value("irq", 32'(irq), 32'h1);
        apb_write(make_addr(SLOT_KEYPAD, REG_KEY_STATUS), 32'(1) << k);
        repeat (2) @(posedge clk);
        check_value("irq", 32'(irq), 32'h0);
        apb_read(make_addr(SLOT_KEYPAD, REG_KEY_STATUS), data, err);
        check_value("key_status", data, 32'h0);
        @(posedge clk);
        pressed <= '0;
        wait_key_state(k, 1'b0);
        check_value("irq", 32'(irq), 32'h0);

        $display("Test passed");
        $finish;
    end

endmodule

// File: apb_periph_sys.sv
//--------------------
// Peripheral subsystem top
// APB slave mux, LED block and keypad block
//--------------------

`timescale 1ns/1ps

module apb_periph_sys #(
    parameter int SCAN_DIV        = 1000,
    parameter int DEBOUNCE_CYCLES = 20000
) (
    input  logic                               clk,
    input  logic                               RSTn,
    input  periph_pkg::apb_req_t               apb_req,
    output periph_pkg::apb_rsp_t               apb_rsp,
    input  logic [keypad_pkg::KP_COLS-1:0]     col,
    output logic [keypad_pkg::KP_ROWS-1:0]     row,
    output logic [periph_pkg::LED_WIDTH-1:0]   led,
    output logic                               irq
);

    import periph_pkg::*;

    apb_req_t led_req;
    apb_rsp_t led_rsp;
    apb_req_t key_req;
    apb_rsp_t key_rsp;
    logic     key_irq;

    apb_slave_mux u_mux (
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .led_req  (led_req),
        .led_rsp  (led_rsp),
        .key_req  (key_req),
        .key_rsp  (key_rsp),
        .key_irq  (key_irq),
        .irq      (irq)
    );

    // Slot 0
    apb_led u_led (
        .clk      (clk),
        .RSTn     (RSTn),
        .apb_req  (led_req),
        .apb_rsp  (led_rsp),
        .led      (led)
    );

    // Slot 1
    apb_keypad #(
        .SCAN_DIV        (SCAN_DIV),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_keypad (
        .clk      (clk),
        .RSTn     (RSTn),
        .apb_req  (key_req),
        .apb_rsp  (key_rsp),
        .col      (col),
        .row      (row),
        .irq      (key_irq)
    );

endmodule

// File: apb_keypad.sv
//--------------------
// APB keypad block
// State, press status and enable registers, interrupt,
// matrix scanner and debouncer
//--------------------

`timescale 1ns/1ps

module apb_keypad #(
    parameter int SCAN_DIV        = 1000,
    parameter int DEBOUNCE_CYCLES = 20000
) (
    input  logic                            clk,
    input  logic                            RSTn,
    input  periph_pkg::apb_req_t            apb_req,
    output periph_pkg::apb_rsp_t            apb_rsp,
    input  logic [keypad_pkg::KP_COLS-1:0]  col,
    output logic [keypad_pkg::KP_ROWS-1:0]  row,
    output logic                            irq
);

    import periph_pkg::*;
    import keypad_pkg::*;

    key_vec_t          raw_keys;
    key_vec_t          key_state;       // Debounced
    key_vec_t          key_state_q;
    key_vec_t          key_status;
    key_vec_t          key_enable;
    key_vec_t          key_rise;
    key_vec_t          status_clr;
    logic [OFFS_W-1:0] offset;
    logic              wr_en;

    keypad_scan #(
        .SCAN_DIV        (SCAN_DIV)
    ) u_scan (
        .clk             (clk),
        .RSTn            (RSTn),
        .col             (col),
        .row             (row),
        .raw_keys        (raw_keys)
    );

    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_debounce (
        .clk             (clk),
        .RSTn            (RSTn),
        .raw_keys        (raw_keys),
        .keys            (key_state)
    );

    //--------------------
    // Registers
    //--------------------
    assign offset     = apb_req.addr.f.offset;
    assign wr_en      = apb_req.sel & apb_req.enable & apb_req.write;
    assign key_rise   = key_state & ~key_state_q;
    assign status_clr = (wr_en && offset == REG_KEY_STATUS) ? apb_req.wdata[KP_KEYS-1:0] : '0;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            key_state_q <= '0;
            key_status  <= '0;
            key_enable  <= '0;
            irq         <= 1'b0;
        end else begin
            key_state_q <= key_state;
            key_status  <= (key_status & ~status_clr) | key_rise;  // New press wins over clear
            if (wr_en && offset == REG_KEY_ENABLE) begin
                key_enable <= apb_req.wdata[KP_KEYS-1:0];
            end
            irq <= |(key_status & key_enable);
        end
    end

    // Read mux
    always_comb begin
        apb_rsp.ready  = 1'b1;
        apb_rsp.slverr = 1'b0;
        case (offset)
            REG_KEY_STATE:  apb_rsp.rdata = APB_DATA_W'(key_state);
            REG_KEY_STATUS: apb_rsp.rdata = APB_DATA_W'(key_status);
            REG_KEY_ENABLE: apb_rsp.rdata = APB_DATA_W'(key_enable);
            default:        apb_rsp.rdata = '0;
        endcase
    end

endmodule

// File: key_debounce.sv
//--------------------
// Key debouncer
// One stability counter per key
//--------------------

`timescale 1ns/1ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 20000
) (
    input  logic                  clk,
    input  logic                  RSTn,
    input  keypad_pkg::key_vec_t  raw_keys,
    output keypad_pkg::key_vec_t  keys
);

    import keypad_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] cnt [KP_KEYS];

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            keys <= '0;
            for (int i = 0; i < KP_KEYS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < KP_KEYS; i++) begin
                if (raw_keys[i] == keys[i]) begin
                    cnt[i] <= '0;                   // Nothing pending
                end else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES)) begin
                    keys[i] <= raw_keys[i];         // Stable long enough
                    cnt[i]  <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: keypad_scan.sv
//--------------------
// Keypad matrix scanner
// Row drive rotation and column sampling
//--------------------

`timescale 1ns/1ps

module keypad_scan #(
    parameter int SCAN_DIV = 1000
) (
    input  logic                            clk,
    input  logic                            RSTn,
    input  logic [keypad_pkg::KP_COLS-1:0]  col,        // Active low
    output logic [keypad_pkg::KP_ROWS-1:0]  row,        // Active low one-hot
    output keypad_pkg::key_vec_t            raw_keys
);

    import keypad_pkg::*;

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    row_idx_t         row_idx;
    logic             row_end;

    //--------------------
    // Row period divider
    //--------------------
    assign row_end = (div_cnt == DIV_W'(SCAN_DIV - 1));

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            div_cnt  <= '0;
            row_idx  <= '0;
            raw_keys <= '0;
        end else if (row_end) begin
            div_cnt <= '0;
            // Columns have settled by the last cycle of the row
            raw_keys[row_idx*KP_COLS +: KP_COLS] <= ~col;
            if (row_idx == row_idx_t'(KP_ROWS - 1)) begin
                row_idx <= '0;
            end else begin
                row_idx <= row_idx + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Pull the active row low
    assign row = ~(KP_ROWS'(1) << row_idx);

endmodule

// File: apb_led.sv
//--------------------
// APB LED block
// One data register driving the LED outputs
//--------------------

`timescale 1ns/1ps

module apb_led (
    input  logic                               clk,
    input  logic                               RSTn,
    input  periph_pkg::apb_req_t               apb_req,
    output periph_pkg::apb_rsp_t               apb_rsp,
    output logic [periph_pkg::LED_WIDTH-1:0]   led
);

    import periph_pkg::*;

    logic data_hit;
    logic wr_en;

    assign data_hit = (apb_req.addr.f.offset == REG_LED_DATA);
    assign wr_en    = apb_req.sel & apb_req.enable & apb_req.write & data_hit;

    // Loaded at the end of the access phase
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            led <= '0;
        end else if (wr_en) begin
            led <= apb_req.wdata[LED_WIDTH-1:0];
        end
    end

    // Zero wait and never an error
    always_comb begin
        apb_rsp.ready  = 1'b1;
        apb_rsp.slverr = 1'b0;
        apb_rsp.rdata  = data_hit ? APB_DATA_W'(led) : '0;  // Other offsets read 0
    end

endmodule

// File: apb_slave_mux.sv
//--------------------
// APB slave mux
// Slot decode on address bits 15:12, per-slave select,
// response and interrupt combination
//--------------------

`timescale 1ns/1ps

module apb_slave_mux (
    input  periph_pkg::apb_req_t apb_req,
    output periph_pkg::apb_rsp_t apb_rsp,

    output periph_pkg::apb_req_t led_req,
    input  periph_pkg::apb_rsp_t led_rsp,

    output periph_pkg::apb_req_t key_req,
    input  periph_pkg::apb_rsp_t key_rsp,

    input  logic                 key_irq,
    output logic                 irq
);

    import periph_pkg::*;

    logic [SLOT_W-1:0] slot;
    logic              led_hit;
    logic              key_hit;

    //--------------------
    // Decode
    //--------------------
    assign slot    = apb_req.addr.f.slot;
    assign led_hit = (slot == SLOT_LED);
    assign key_hit = (slot == SLOT_KEYPAD);

    // Fields are shared, only sel is steered
    always_comb begin
        led_req     = apb_req;
        led_req.sel = apb_req.sel & led_hit;

        key_req     = apb_req;
        key_req.sel = apb_req.sel & key_hit;
    end

    //--------------------
    // Response select
    //--------------------
    always_comb begin
        if (led_hit) begin
            apb_rsp = led_rsp;
        end else if (key_hit) begin
            apb_rsp = key_rsp;
        end else begin
            // Unmapped slot completes at once with an error
            apb_rsp.ready  = 1'b1;
            apb_rsp.slverr = 1'b1;
            apb_rsp.rdata  = '0;
        end
    end

    // Single interrupt source for now
    assign irq = key_irq;

endmodule

// File: keypad_pkg.sv
//--------------------
// Keypad definitions
// Matrix geometry, key vector and row index types,
// register field width
//--------------------

package keypad_pkg;

    localparam int KP_ROWS = 4;
    localparam int KP_COLS = 4;

    // One register field bit per key
    localparam int KP_KEYS = KP_ROWS * KP_COLS;

    // Bit index is row * KP_COLS + column
    typedef logic [KP_KEYS-1:0] key_vec_t;

    // Currently driven row
    typedef logic [$clog2(KP_ROWS)-1:0] row_idx_t;

endpackage

// File: periph_pkg.sv
//--------------------
// Peripheral bus definitions
// APB request and response structs, address union,
// slot map and register offsets
//--------------------

package periph_pkg;

    //--------------------
    // Bus widths
    //--------------------
    localparam int APB_ADDR_W = 16;
    localparam int APB_DATA_W = 32;

    localparam int SLOT_W = 4;      // Address bits 15:12
    localparam int OFFS_W = 4;      // Address bits 3:0
    localparam int GAP_W  = APB_ADDR_W - SLOT_W - OFFS_W;

    // Field view of an APB address
    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        logic [GAP_W-1:0]  gap;     // Not decoded
        logic [OFFS_W-1:0] offset;
    } apb_addr_f_t;

    // Same address word, raw or split into slot and offset
    typedef union packed {
        logic [APB_ADDR_W-1:0] raw;
        apb_addr_f_t           f;
    } apb_addr_u;

    typedef struct packed {
        logic                  sel;
        logic                  enable;
        logic                  write;
        apb_addr_u             addr;
        logic [APB_DATA_W-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic                  ready;
        logic                  slverr;
        logic [APB_DATA_W-1:0] rdata;
    } apb_rsp_t;

    //--------------------
    // Slot map
    //--------------------
    localparam logic [SLOT_W-1:0] SLOT_LED    = 4'd0;
    localparam logic [SLOT_W-1:0] SLOT_KEYPAD = 4'd1;

    // LED block
    localparam int LED_WIDTH = 8;
    localparam logic [OFFS_W-1:0] REG_LED_DATA = 4'd0;

    // Keypad block
    localparam logic [OFFS_W-1:0] REG_KEY_STATE  = 4'd0;    // Read only
    localparam logic [OFFS_W-1:0] REG_KEY_STATUS = 4'd4;    // Write 1 to clear
    localparam logic [OFFS_W-1:0] REG_KEY_ENABLE = 4'd8;

endpackage
